/* Bender.yml */
package:
  name: cpu_core

sources:
  - cpu_pkg.sv
  - instr_sequencer.sv
  - alu.sv
  - register_bank.sv
  - cpu_core.sv
  - target: test
    files:
      - tb_cpu_core.sv

/* alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 instr_en,
    input  wire [7:0]           instr,
    input  wire cpu_pkg::core_ctrl_t ctrl,
    input  wire [7:0]           src_data,
    input  wire cpu_pkg::flags_t status,
    output logic [7:0]          result,
    output cpu_pkg::flags_t     result_flags
);

    logic [7:0] operand_q;
    logic [7:0] opnd;
    logic [7:0] res;
    logic       carry;

    always_ff @(posedge clk) begin
        if (instr_en && ctrl.operand_load)
            operand_q <= instr;  // Immediate byte
    end

    assign opnd = ctrl.alu_from_latch ? operand_q : src_data;

    always_comb begin
        res   = opnd;
        carry = status.c;
        case (ctrl.alu_op)
            cpu_pkg::alu_asl: {carry, res} = {opnd, 1'b0};
            cpu_pkg::alu_lsr: {res, carry} = {1'b0, opnd};
            cpu_pkg::alu_rol: {carry, res} = {opnd, status.c};
            cpu_pkg::alu_ror: {res, carry} = {status.c, opnd};
            cpu_pkg::alu_inc: res = opnd + 8'd1;
            cpu_pkg::alu_dec: res = opnd - 8'd1;
            default:          res = opnd;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result       <= 8'h00;
            result_flags <= '{n: 1'b0, z: 1'b0, c: 1'b0};
        end else if (instr_en && ctrl.alu_go) begin
            result         <= res;
            result_flags.n <= res[7];
            result_flags.z <= (res == 8'h00);
            result_flags.c <= carry;
        end
    end

    // Operand capture and execute are separate sequencer states
    a_go_vs_load: assert property (@(posedge clk) disable iff (!rst_n)
        !(ctrl.alu_go && ctrl.operand_load));

endmodule

`default_nettype wire

/* cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             instr_en,
    input  wire [7:0]       instr,
    output logic            fetch,
    output logic [7:0]      regs_a,
    output logic [7:0]      regs_x,
    output logic [7:0]      regs_y,
    output cpu_pkg::flags_t status
);

    cpu_pkg::core_ctrl_t ctrl;
    logic [7:0]          src_data;
    logic [7:0]          result;
    cpu_pkg::flags_t     result_flags;

    instr_sequencer u_seq (
        .clk      (clk),
        .rst_n    (rst_n),
        .instr_en (instr_en),
        .instr    (instr),
        .fetch    (fetch),
        .ctrl     (ctrl)
    );

    alu u_alu (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_en     (instr_en),
        .instr        (instr),
        .ctrl         (ctrl),
        .src_data     (src_data),
        .status       (status),  // Carry in for rotates
        .result       (result),
        .result_flags (result_flags)
    );

    register_bank u_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_en     (instr_en),
        .ctrl         (ctrl),
        .result       (result),
        .result_flags (result_flags),
        .src_data     (src_data),
        .regs_a       (regs_a),
        .regs_x       (regs_x),
        .regs_y       (regs_y),
        .status       (status)
    );

endmodule

`default_nettype wire

/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    // Standard 6502 encodings
    localparam logic [7:0] op_nop     = 8'hea;
    localparam logic [7:0] op_sec     = 8'h38;
    localparam logic [7:0] op_clc     = 8'h18;
    localparam logic [7:0] op_tax     = 8'haa;
    localparam logic [7:0] op_tay     = 8'ha8;
    localparam logic [7:0] op_txa     = 8'h8a;
    localparam logic [7:0] op_tya     = 8'h98;
    localparam logic [7:0] op_inx     = 8'he8;
    localparam logic [7:0] op_iny     = 8'hc8;
    localparam logic [7:0] op_dex     = 8'hca;
    localparam logic [7:0] op_dey     = 8'h88;
    localparam logic [7:0] op_lda_imm = 8'ha9;
    localparam logic [7:0] op_ldx_imm = 8'ha2;
    localparam logic [7:0] op_ldy_imm = 8'ha0;

    localparam logic [2:0] adr_accum = 3'b010;  // bbb of the accumulator forms
    localparam logic [1:0] grp_shift = 2'b10;

    // aaa field within the shift group
    localparam logic [2:0] aaa_asl = 3'b000;
    localparam logic [2:0] aaa_rol = 3'b001;
    localparam logic [2:0] aaa_lsr = 3'b010;
    localparam logic [2:0] aaa_ror = 3'b011;

    typedef struct packed {
        logic [2:0] aaa;
        logic [2:0] bbb;
        logic [1:0] cc;
    } opcode_fields_t;

    typedef union packed {
        logic [7:0]     raw;
        opcode_fields_t fields;
    } opcode_u;

    typedef enum logic [2:0] {
        alu_pass, alu_asl, alu_lsr, alu_rol, alu_ror, alu_inc, alu_dec
    } alu_op_e;

    typedef enum logic [1:0] {sel_a, sel_x, sel_y, sel_none} reg_sel_e;

    typedef enum logic [2:0] {
        s_fetch, s_decode, s_operand, s_alu, s_writeback
    } state_e;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
    } flags_t;

    localparam flags_t flags_nz  = '{n: 1'b1, z: 1'b1, c: 1'b0};
    localparam flags_t flags_nzc = '{n: 1'b1, z: 1'b1, c: 1'b1};

    typedef struct packed {
        alu_op_e  alu_op;
        logic     alu_from_latch;  // Operand latch instead of source register
        logic     alu_go;
        logic     operand_load;
        reg_sel_e src_sel;
        reg_sel_e dst_sel;
        logic     wb_from_alu;
        flags_t   flag_we;
        logic     carry_set;
        logic     carry_value;
    } core_ctrl_t;

    localparam core_ctrl_t ctrl_idle = '{
        alu_op: alu_pass, alu_from_latch: 1'b0, alu_go: 1'b0, operand_load: 1'b0,
        src_sel: sel_none, dst_sel: sel_none, wb_from_alu: 1'b0,
        flag_we: '{n: 1'b0, z: 1'b0, c: 1'b0}, carry_set: 1'b0, carry_value: 1'b0
    };

endpackage

`default_nettype wire

/* instr_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_sequencer (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 instr_en,
    input  wire [7:0]           instr,
    output logic                fetch,
    output cpu_pkg::core_ctrl_t ctrl
);

    cpu_pkg::state_e   state_q;
    cpu_pkg::state_e   state_d;
    cpu_pkg::opcode_u  opcode_q;
    logic              is_imm;
    logic              is_alu;
    cpu_pkg::reg_sel_e dec_reg;
    cpu_pkg::alu_op_e  dec_op;
    cpu_pkg::flags_t   dec_flags;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= cpu_pkg::s_fetch;
            opcode_q.raw <= cpu_pkg::op_nop;
        end else if (instr_en) begin
            state_q <= state_d;
            if (state_q == cpu_pkg::s_fetch)
                opcode_q.raw <= instr;
        end
    end

    // Classify the latched opcode
    always_comb begin
        is_imm    = 1'b0;
        is_alu    = 1'b0;
        dec_reg   = cpu_pkg::sel_none;
        dec_op    = cpu_pkg::alu_pass;
        dec_flags = cpu_pkg::flags_nz;
        case (opcode_q.raw)
            cpu_pkg::op_lda_imm: begin
                is_imm  = 1'b1;
                dec_reg = cpu_pkg::sel_a;
            end
            cpu_pkg::op_ldx_imm: begin
                is_imm  = 1'b1;
                dec_reg = cpu_pkg::sel_x;
            end
            cpu_pkg::op_ldy_imm: begin
                is_imm  = 1'b1;
                dec_reg = cpu_pkg::sel_y;
            end
            cpu_pkg::op_inx, cpu_pkg::op_dex: begin
                is_alu  = 1'b1;
                dec_reg = cpu_pkg::sel_x;
                dec_op  = (opcode_q.raw == cpu_pkg::op_inx) ? cpu_pkg::alu_inc : cpu_pkg::alu_dec;
            end
            cpu_pkg::op_iny, cpu_pkg::op_dey: begin
                is_alu  = 1'b1;
                dec_reg = cpu_pkg::sel_y;
                dec_op  = (opcode_q.raw == cpu_pkg::op_iny) ? cpu_pkg::alu_inc : cpu_pkg::alu_dec;
            end
            default: begin
                // TXA, TAX, DEX and NOP share bbb/cc with the shifts and differ in aaa
                if (opcode_q.fields.bbb == cpu_pkg::adr_accum &&
                    opcode_q.fields.cc == cpu_pkg::grp_shift &&
                    opcode_q.fields.aaa inside {cpu_pkg::aaa_asl, cpu_pkg::aaa_rol,
                                                cpu_pkg::aaa_lsr, cpu_pkg::aaa_ror}) begin
                    is_alu    = 1'b1;
                    dec_reg   = cpu_pkg::sel_a;
                    dec_flags = cpu_pkg::flags_nzc;
                    case (opcode_q.fields.aaa)
                        cpu_pkg::aaa_asl: dec_op = cpu_pkg::alu_asl;
                        cpu_pkg::aaa_rol: dec_op = cpu_pkg::alu_rol;
                        cpu_pkg::aaa_lsr: dec_op = cpu_pkg::alu_lsr;
                        cpu_pkg::aaa_ror: dec_op = cpu_pkg::alu_ror;
                        default:          dec_op = cpu_pkg::alu_pass;
                    endcase
                end
            end
        endcase
    end

    // Control word and next state
    always_comb begin
        ctrl    = cpu_pkg::ctrl_idle;
        state_d = state_q;
        case (state_q)
            cpu_pkg::s_fetch: state_d = cpu_pkg::s_decode;
            cpu_pkg::s_decode: begin
                state_d = cpu_pkg::s_fetch;
                if (is_imm)
                    state_d = cpu_pkg::s_operand;
                else if (is_alu)
                    state_d = cpu_pkg::s_alu;
                else begin
                    case (opcode_q.raw)
                        cpu_pkg::op_sec, cpu_pkg::op_clc: begin
                            ctrl.carry_set   = 1'b1;
                            ctrl.carry_value = (opcode_q.raw == cpu_pkg::op_sec);
                        end
                        cpu_pkg::op_tax, cpu_pkg::op_tay: begin
                            ctrl.src_sel = cpu_pkg::sel_a;
                            ctrl.dst_sel = (opcode_q.raw == cpu_pkg::op_tax) ?
                                           cpu_pkg::sel_x : cpu_pkg::sel_y;
                        end
                        cpu_pkg::op_txa: begin
                            ctrl.src_sel = cpu_pkg::sel_x;
                            ctrl.dst_sel = cpu_pkg::sel_a;
                        end
                        cpu_pkg::op_tya: begin
                            ctrl.src_sel = cpu_pkg::sel_y;
                            ctrl.dst_sel = cpu_pkg::sel_a;
                        end
                        default: ;  // NOP and unknown opcodes
                    endcase
                end
            end
            cpu_pkg::s_operand: begin
                ctrl.operand_load = 1'b1;
                state_d           = cpu_pkg::s_alu;
            end
            cpu_pkg::s_alu: begin
                ctrl.alu_go         = 1'b1;
                ctrl.alu_op         = dec_op;
                ctrl.alu_from_latch = is_imm;
                ctrl.src_sel        = is_imm ? cpu_pkg::sel_none : dec_reg;
                state_d             = cpu_pkg::s_writeback;
            end
            cpu_pkg::s_writeback: begin
                ctrl.dst_sel     = dec_reg;
                ctrl.wb_from_alu = 1'b1;
                ctrl.flag_we     = dec_flags;
                state_d          = cpu_pkg::s_fetch;
            end
            default: state_d = cpu_pkg::s_fetch;
        endcase
    end

    assign fetch = (state_q == cpu_pkg::s_fetch) || (state_q == cpu_pkg::s_operand);

    a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        state_q inside {cpu_pkg::s_fetch, cpu_pkg::s_decode, cpu_pkg::s_operand,
                        cpu_pkg::s_alu, cpu_pkg::s_writeback});

    // A consumed byte always moves the FSM out of the fetch states
    a_fetch_state: assert property (@(posedge clk) disable iff (!rst_n)
        (fetch && instr_en) |=> !fetch);

endmodule

`default_nettype wire

/* register_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module register_bank (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  instr_en,
    input  wire cpu_pkg::core_ctrl_t ctrl,
    input  wire [7:0]            result,
    input  wire cpu_pkg::flags_t result_flags,
    output logic [7:0]           src_data,
    output logic [7:0]           regs_a,
    output logic [7:0]           regs_x,
    output logic [7:0]           regs_y,
    output cpu_pkg::flags_t      status
);

    logic [7:0] wr_data;

    always_comb begin
        case (ctrl.src_sel)
            cpu_pkg::sel_a: src_data = regs_a;
            cpu_pkg::sel_x: src_data = regs_x;
            cpu_pkg::sel_y: src_data = regs_y;
            default:        src_data = 8'h00;
        endcase
    end

    assign wr_data = ctrl.wb_from_alu ? result : src_data;  // ALU or transfer

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs_a <= 8'h00;
            regs_x <= 8'h00;
            regs_y <= 8'h00;
            status <= '{n: 1'b0, z: 1'b0, c: 1'b0};
        end else if (instr_en) begin
            case (ctrl.dst_sel)
                cpu_pkg::sel_a: regs_a <= wr_data;
                cpu_pkg::sel_x: regs_x <= wr_data;
                cpu_pkg::sel_y: regs_y <= wr_data;
                default: ;
            endcase
            if (ctrl.flag_we.n)
                status.n <= result_flags.n;
            if (ctrl.flag_we.z)
                status.z <= result_flags.z;
            if (ctrl.carry_set)
                status.c <= ctrl.carry_value;  // SEC / CLC
            else if (ctrl.flag_we.c)
                status.c <= result_flags.c;
        end
    end

    // ALU flags only accompany a real register write
    a_wb_target: assert property (@(posedge clk) disable iff (!rst_n)
        (ctrl.wb_from_alu && ctrl.flag_we != '0) |-> ctrl.dst_sel != cpu_pkg::sel_none);

endmodule

`default_nettype wire

/* tb.f */
cpu_pkg.sv
instr_sequencer.sv
alu.sv
register_bank.sv
cpu_core.sv
tb_cpu_core.sv

/* tb_cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_core;

    localparam logic [7:0]  op_asl_a  = 8'h0a;
    localparam logic [7:0]  op_rol_a  = 8'h2a;
    localparam logic [7:0]  op_lsr_a  = 8'h4a;
    localparam logic [7:0]  op_ror_a  = 8'h6a;
    localparam logic [31:0] shift_ops = {op_ror_a, op_lsr_a, op_rol_a, op_asl_a};
    localparam logic [31:0] edge_vals = 32'h80_7f_00_ff;  // Wrap and sign corners

    localparam int n_rand       = 6;
    localparam int rst_cycles   = 4;
    localparam int stall_cycles = 6;
    localparam int n_instr      = 280;  // Upper bound on instructions issued below
    localparam int cycle_limit  = 6 * (5 * n_instr + rst_cycles + 2 * stall_cycles);

    logic            clk;
    logic            rst_n;
    logic            instr_en;
    logic [7:0]      instr;
    logic            fetch;
    logic [7:0]      regs_a;
    logic [7:0]      regs_x;
    logic [7:0]      regs_y;
    cpu_pkg::flags_t status;

    // Reference model
    logic [7:0]  m_a;
    logic [7:0]  m_x;
    logic [7:0]  m_y;
    logic        m_n;
    logic        m_z;
    logic        m_c;
    logic [31:0] lcg_state = 32'ha543;
    int          cycles = 0;

    cpu_core DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .instr_en (instr_en),
        .instr    (instr),
        .fetch    (fetch),
        .regs_a   (regs_a),
        .regs_x   (regs_x),
        .regs_y   (regs_y),
        .status   (status)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the core did not finish within %0d clock cycles", cycle_limit);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [7:0] rand_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic check_val(input string what, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %0t ns: %s is %02h, expected %02h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_state(input string ctx);
        check_val({ctx, ": A"}, regs_a, m_a);
        check_val({ctx, ": X"}, regs_x, m_x);
        check_val({ctx, ": Y"}, regs_y, m_y);
        check_val({ctx, ": NZC"}, {5'b0, status.n, status.z, status.c}, {5'b0, m_n, m_z, m_c});
    endtask

    // Present a byte and hold it until the core takes it
    task automatic send_byte(input logic [7:0] b);
        instr    = b;
        instr_en = 1'b1;
        while (!fetch)
            step();
        step();
    endtask

    task automatic wait_done();
        while (!fetch)
            step();
    endtask

    task automatic set_nz(input logic [7:0] v);
        m_n = v[7];
        m_z = (v == 8'h00);
    endtask

    task automatic apply_model(input logic [7:0] op, input logic [7:0] opnd);
        logic old_c;
        old_c = m_c;
        case (op)
            cpu_pkg::op_sec:     m_c = 1'b1;
            cpu_pkg::op_clc:     m_c = 1'b0;
            cpu_pkg::op_tax:     m_x = m_a;
            cpu_pkg::op_tay:     m_y = m_a;
            cpu_pkg::op_txa:     m_a = m_x;
            cpu_pkg::op_tya:     m_a = m_y;
            cpu_pkg::op_inx:     m_x = m_x + 8'd1;
            cpu_pkg::op_dex:     m_x = m_x - 8'd1;
            cpu_pkg::op_iny:     m_y = m_y + 8'd1;
            cpu_pkg::op_dey:     m_y = m_y - 8'd1;
            cpu_pkg::op_lda_imm: m_a = opnd;
            cpu_pkg::op_ldx_imm: m_x = opnd;
            cpu_pkg::op_ldy_imm: m_y = opnd;
            op_asl_a: begin
                m_c = m_a[7];
                m_a = m_a << 1;
            end
            op_lsr_a: begin
                m_c = m_a[0];
                m_a = m_a >> 1;
            end
            op_rol_a: begin
                m_c = m_a[7];
                m_a = {m_a[6:0], old_c};
            end
            op_ror_a: begin
                m_c = m_a[0];
                m_a = {old_c, m_a[7:1]};
            end
            default: ;  // NOP and unknown opcodes
        endcase
        // N and Z for loads, increments, decrements and shifts
        case (op)
            cpu_pkg::op_inx, cpu_pkg::op_dex, cpu_pkg::op_ldx_imm: set_nz(m_x);
            cpu_pkg::op_iny, cpu_pkg::op_dey, cpu_pkg::op_ldy_imm: set_nz(m_y);
            cpu_pkg::op_lda_imm, op_asl_a, op_lsr_a, op_rol_a, op_ror_a: set_nz(m_a);
            default: ;
        endcase
    endtask

    task automatic run_instr(input logic [7:0] op);
        send_byte(op);
        wait_done();
        apply_model(op, 8'h00);
        check_state($sformatf("opcode %02h", op));
    endtask

    task automatic run_imm(input logic [7:0] op, input logic [7:0] v);
        send_byte(op);
        send_byte(v);
        wait_done();
        apply_model(op, v);
        check_state($sformatf("opcode %02h #%02h", op, v));
    endtask

    task automatic check_reset();
        check_val("fetch after reset", {7'b0, fetch}, 8'h01);
        check_state("reset");
    endtask

    task automatic test_loads();
        logic [7:0] v;
        run_instr(cpu_pkg::op_sec);  // C must survive the loads
        for (int i = 0; i < n_rand + 2; i++) begin
            v = (i == 0) ? 8'h00 : (i == 1) ? 8'h80 : rand_byte();
            run_imm(cpu_pkg::op_lda_imm, v);
            run_imm(cpu_pkg::op_ldx_imm, v);
            run_imm(cpu_pkg::op_ldy_imm, v);
        end
    endtask

    // Each transfer moves a value whose N and Z differ from the current flags
    task automatic test_transfers();
        run_imm(cpu_pkg::op_lda_imm, rand_byte() | 8'h80);
        run_imm(cpu_pkg::op_ldy_imm, 8'h00);
        run_instr(cpu_pkg::op_tax);
        run_instr(cpu_pkg::op_tay);
        run_imm(cpu_pkg::op_ldx_imm, 8'h80);
        run_imm(cpu_pkg::op_ldy_imm, 8'h01);
        run_instr(cpu_pkg::op_txa);
        run_imm(cpu_pkg::op_ldy_imm, 8'h00);
        run_imm(cpu_pkg::op_ldx_imm, 8'h7f);
        run_instr(cpu_pkg::op_tya);
        run_instr(cpu_pkg::op_nop);
        run_instr(8'h02);
        run_instr(8'hff);
    endtask

    task automatic test_inc_dec();
        logic [7:0] v;
        for (int i = 0; i < 4 + n_rand; i++) begin
            v = (i < 4) ? edge_vals[i*8 +: 8] : rand_byte();
            run_instr(v[0] ? cpu_pkg::op_sec : cpu_pkg::op_clc);
            run_imm(cpu_pkg::op_ldx_imm, v);
            run_instr(cpu_pkg::op_inx);
            run_imm(cpu_pkg::op_ldx_imm, v);
            run_instr(cpu_pkg::op_dex);
            run_imm(cpu_pkg::op_ldy_imm, v);
            run_instr(cpu_pkg::op_iny);
            run_imm(cpu_pkg::op_ldy_imm, v);
            run_instr(cpu_pkg::op_dey);
        end
    endtask

    task automatic test_shifts();
        run_instr(cpu_pkg::op_sec);
        run_instr(cpu_pkg::op_clc);
        for (int i = 0; i < n_rand; i++)
            for (int k = 0; k < 4; k++)
                for (int c = 0; c < 2; c++) begin
                    run_imm(cpu_pkg::op_lda_imm, rand_byte());
                    run_instr(c ? cpu_pkg::op_sec : cpu_pkg::op_clc);
                    run_instr(shift_ops[k*8 +: 8]);
                end
    endtask

    task automatic hold_stalled(input logic exp_fetch);
        instr_en = 1'b0;
        repeat (stall_cycles) begin
            step();
            check_val("fetch while stalled", {7'b0, fetch}, {7'b0, exp_fetch});
            check_state("stall");
        end
    endtask

    task automatic test_stall();
        logic [7:0] v;
        v = rand_byte();
        send_byte(cpu_pkg::op_lda_imm);
        instr = ~v;  // Wrong byte on the bus while stalled
        hold_stalled(1'b0);
        instr_en = 1'b1;
        while (!fetch)
            step();
        hold_stalled(1'b1);  // Waiting for the operand
        send_byte(v);
        wait_done();
        apply_model(cpu_pkg::op_lda_imm, v);
        check_state("LDA after stall");
    endtask

    initial begin
        rst_n    = 1'b0;
        instr_en = 1'b0;
        instr    = 8'h00;
        m_a      = 8'h00;
        m_x      = 8'h00;
        m_y      = 8'h00;
        m_n      = 1'b0;
        m_z      = 1'b0;
        m_c      = 1'b0;
        repeat (rst_cycles) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_reset();
        test_loads();
        test_transfers();
        test_inc_dec();
        test_shifts();
        test_stall();
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire
